/* flist.f */
cnn_geom_pkg.sv
cnn_stream_pkg.sv
block_fetch.sv
tap_sequencer.sv
result_writeback.sv
result_store.sv
conv_layer_reader.sv
tb_conv_layer_reader.sv

/* Bender.yml */
package:
  name: conv_layer_reader

sources:
  - cnn_geom_pkg.sv
  - cnn_stream_pkg.sv
  - block_fetch.sv
  - tap_sequencer.sv
  - result_writeback.sv
  - result_store.sv
  - conv_layer_reader.sv
  - target: test
    files:
      - tb_conv_layer_reader.sv

/* tb_conv_layer_reader.sv */
`timescale 1ns/1ps

module tb_conv_layer_reader;
    import cnn_geom_pkg::*;
    import cnn_stream_pkg::*;

    logic clk;
    logic reset;
    logic start;
    pixel_t [3:0] image_quad;
    pixel_t param_data;
    result_t result_in;
    bank_req_t host_req;
    image_addr_t image_addr;
    param_addr_t param_addr;
    stream_beat_t beat;
    logic busy;
    logic done;
    logic host_rd_valid;
    pixel_t host_rd_data;

    pixel_t image_mem [4][32];    // Bank, quad address
    pixel_t param_mem [32];
    image_addr_t image_addr_q;
    param_addr_t param_addr_q;
    integer seed;
    logic collecting;
    stream_beat_t beats [$];
    int done_cnt;
    int beats_at_done;
    logic busy_at_done;

    conv_layer_reader UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Image banks and parameter memory answer one cycle after the address
    always @(negedge clk) begin
        for (int b = 0; b < 4; b++)
            image_quad[b] <= image_mem[b][image_addr_q];
        param_data   <= param_mem[param_addr_q];
        image_addr_q <= image_addr;
        param_addr_q <= param_addr;
    end

    always @(posedge clk) begin
        if (collecting) begin
            if (beat.valid)
                beats.push_back(beat);
            if (done) begin
                done_cnt++;
                beats_at_done = beats.size();
                busy_at_done  = busy;
            end
        end
    end

    task automatic fail_now();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            fail_now();
        end
    endtask

    task automatic fill_memories();
        seed = 32'h6696_e951;
        for (int a = 0; a < 32; a++) begin
            param_mem[a] = 8'($random(seed));
            for (int b = 0; b < 4; b++)
                image_mem[b][a] = 8'($random(seed));
        end
    endtask

    // Expected beat number idx within a block
    function automatic stream_beat_t expected_beat(int base, int filter, int idx);
        stream_beat_t b;
        int r;
        int c;
        b = '0;
        b.valid = 1'b1;
        if (idx == 0) begin
            b.lanes.ctrl.kind      = BEAT_HEADER;
            b.lanes.ctrl.mac_count = 16'd9;
            b.param                = param_mem[filter * PARAMS_PER_FILTER];
        end else if (idx <= 9) begin
            for (int j = 0; j < 4; j++) begin
                r = (idx - 1) / 3 + j / 2;
                c = (idx - 1) % 3 + j % 2;
                // Pixel (r, c) lives in quad (r/2, c/2) and in the bank given by its parity
                b.lanes.pix[j] = image_mem[(r % 2) * 2 + c % 2]
                                          [base + (r / 2) * QUADS_PER_ROW + c / 2];
            end
            b.tap   = 1'b1;
            b.param = param_mem[filter * PARAMS_PER_FILTER + idx];
        end else begin
            b.lanes.ctrl.kind = BEAT_SSFR;
            b.lanes.ctrl.ssfr = SSFR_INSTR;
        end
        return b;
    endfunction

    task automatic start_run();
        int cycles;
        beats.delete();
        done_cnt   = 0;
        collecting = 1'b1;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_equal("run busy", 1, busy);
        cycles = 0;
        while (done_cnt == 0) begin
            cycles++;
            if (cycles > 600) begin
                $display("Run did not signal done within 600 cycles");
                fail_now();
            end
            @(negedge clk);
        end
        repeat (4) @(negedge clk);    // Room for a stray second done
        collecting = 1'b0;
    endtask

    task automatic check_block(input string name, input int blk, input int base, input int filter);
        for (int i = 0; i < 11; i++)
            check_equal(name, expected_beat(base, filter, i), beats[blk * 11 + i]);
    endtask

    task automatic host_read(input logic [1:0] bank, input int addr, output pixel_t data);
        int cycles;
        @(negedge clk);
        host_req.valid = 1'b1;
        host_req.bank  = bank;
        host_req.addr  = store_addr_t'(addr);
        cycles = 0;
        @(negedge clk);
        while (!host_rd_valid) begin
            cycles++;
            if (cycles > 20) begin
                $display("Host read of bank %0d address %0d was never answered", bank, addr);
                fail_now();
            end
            @(negedge clk);
        end
        data = host_rd_data;
        host_req.valid = 1'b0;
    endtask

    task automatic test_reset_state();
        pixel_t data;
        result_in.data = 8'h5a;    // Valid stays low
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_equal("reset outputs", 0, {beat.valid, busy, done, host_rd_valid});
        end
        // An unwritten entry reads unknown or zero
        host_read(2'd0, 0, data);
        check_equal("reset readback", 1, $isunknown(data) || data == 8'h00);
    endtask

    task automatic test_first_block();
        start_run();
        check_block("first block", 0, 0, 0);
    endtask

    task automatic test_z_order();
        start_run();
        check_block("z-order block 1", 1, 1, 0);
        check_block("z-order block 2", 2, 5, 0);
        check_block("z-order block 3", 3, 6, 0);
        check_block("z-order block 4", 4, 2, 0);
    endtask

    task automatic test_filter_advance();
        start_run();
        check_block("filter 1 block 16", 16, 0, 1);
        check_equal("beat count", 352, beats.size());
        check_equal("beats before done", 352, beats_at_done);
        check_equal("done pulses", 1, done_cnt);
        check_equal("busy at done", 0, busy_at_done);
        check_equal("busy after run", 0, busy);
    endtask

    task automatic test_writeback_readback();
        pixel_t vals [8];
        pixel_t data;
        for (int n = 0; n < 8; n++)
            vals[n] = 8'($random(seed));
        for (int n = 0; n < 8; n++) begin
            @(negedge clk);
            result_in.valid = 1'b1;
            result_in.data  = vals[n];
        end
        @(negedge clk);
        result_in.valid = 1'b0;
        for (int n = 0; n < 8; n++) begin
            host_read(2'(n % 4), n / 4, data);
            check_equal("readback", vals[n], data);
        end
    endtask

    task automatic test_contention();
        pixel_t vals [12];
        int cycles;
        for (int i = 0; i < 12; i++)
            vals[i] = 8'($random(seed));
        // The held read targets result 19 at bank 3 address 4
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            check_equal("read held during writes", 0, host_rd_valid);
            result_in.valid = 1'b1;
            result_in.data  = vals[i];
            if (i == 1) begin
                host_req.valid = 1'b1;
                host_req.bank  = 2'd3;
                host_req.addr  = 6'd4;
            end
        end
        @(negedge clk);
        check_equal("read held during writes", 0, host_rd_valid);
        result_in.valid = 1'b0;
        cycles = 0;
        while (!host_rd_valid) begin
            cycles++;
            if (cycles > 20) begin
                $display("Held host read was not granted after the writes stopped");
                fail_now();
            end
            @(negedge clk);
        end
        host_req.valid = 1'b0;
        check_equal("contention readback", vals[11], host_rd_data);
    endtask

    initial begin
        collecting    = 1'b0;
        done_cnt      = 0;
        beats_at_done = 0;
        busy_at_done  = 1'b0;
        reset         = 1'b1;
        start         = 1'b0;
        result_in     = '0;
        host_req      = '0;
        image_quad    = '0;
        param_data    = '0;
        image_addr_q  = '0;
        param_addr_q  = '0;
        fill_memories();
        repeat (2) @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_first_block();
        test_z_order();
        test_filter_advance();
        test_writeback_readback();
        test_contention();
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* conv_layer_reader.sv */
`timescale 1ns/1ps

module conv_layer_reader (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  cnn_geom_pkg::pixel_t [3:0]   image_quad,
    input  cnn_geom_pkg::pixel_t         param_data,
    input  cnn_stream_pkg::result_t      result_in,
    input  cnn_stream_pkg::bank_req_t    host_req,
    output cnn_geom_pkg::image_addr_t    image_addr,
    output cnn_geom_pkg::param_addr_t    param_addr,
    output cnn_stream_pkg::stream_beat_t beat,
    output logic                         busy,
    output logic                         done,
    output logic                         host_rd_valid,
    output cnn_geom_pkg::pixel_t         host_rd_data
);
    import cnn_stream_pkg::*;

    fetch_ctrl_t fetch_ctrl;
    bank_req_t wr_req;

    // Address side of the image and parameter memories
    block_fetch u_fetch (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .fetch_ctrl (fetch_ctrl),
        .image_addr (image_addr),
        .param_addr (param_addr),
        .busy       (busy),
        .done       (done)
    );

    tap_sequencer u_seq (
        .clk        (clk),
        .reset      (reset),
        .fetch_ctrl (fetch_ctrl),
        .image_quad (image_quad),
        .param_data (param_data),
        .beat       (beat)
    );

    // MAC results back into the result banks
    result_writeback u_wb (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .result_in (result_in),
        .wr_req    (wr_req)
    );

    result_store u_store (
        .clk           (clk),
        .reset         (reset),
        .wr_req        (wr_req),
        .host_req      (host_req),
        .host_rd_valid (host_rd_valid),
        .host_rd_data  (host_rd_data)
    );

endmodule

/* result_store.sv */
`timescale 1ns/1ps

module result_store (
    input  logic                      clk,
    input  logic                      reset,
    input  cnn_stream_pkg::bank_req_t wr_req,
    input  cnn_stream_pkg::bank_req_t host_req,
    output logic                      host_rd_valid,
    output cnn_geom_pkg::pixel_t      host_rd_data
);
    import cnn_geom_pkg::*;

    logic wr_gnt;
    logic rd_gnt;
    store_addr_t port_addr;     // Single port shared by writer and host
    logic [3:0] bank_we;
    logic [3:0] bank_re;
    pixel_t bank_q [4];
    logic [1:0] rd_bank;

    // Fixed priority, host waits out any write
    assign wr_gnt = wr_req.valid;
    assign rd_gnt = host_req.valid && !wr_gnt && !host_rd_valid;

    assign port_addr = wr_gnt ? wr_req.addr : host_req.addr;

    for (genvar b = 0; b < 4; b++) begin : g_bank
        pixel_t mem [2 ** $bits(store_addr_t)];

        assign bank_we[b] = wr_gnt && (wr_req.bank == 2'(b));
        assign bank_re[b] = rd_gnt && (host_req.bank == 2'(b));

        always_ff @(posedge clk) begin
            if (bank_we[b])
                mem[port_addr] <= wr_req.data;
            else if (bank_re[b])
                bank_q[b] <= mem[port_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            host_rd_valid <= 1'b0;
        else
            host_rd_valid <= rd_gnt;
        if (rd_gnt)
            rd_bank <= host_req.bank;
    end

    assign host_rd_data = bank_q[rd_bank];    // Bank output steered to host

endmodule

/* result_writeback.sv */
`timescale 1ns/1ps

module result_writeback (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  cnn_stream_pkg::result_t   result_in,
    output cnn_stream_pkg::bank_req_t wr_req
);
    import cnn_geom_pkg::*;

    // Low two bits pick the bank, upper bits the address
    logic [$bits(store_addr_t) + 1:0] res_count;
    logic [$bits(store_addr_t) + 1:0] res_idx;

    assign res_idx = start ? '0 : res_count;    // Restart numbering with the run

    always_ff @(posedge clk) begin
        if (reset) begin
            res_count    <= '0;
            wr_req.valid <= 1'b0;
        end else begin
            wr_req.valid <= result_in.valid;
            if (result_in.valid)
                res_count <= res_idx + 1'b1;
            else
                res_count <= res_idx;
        end
        wr_req.bank <= res_idx[1:0];
        wr_req.addr <= store_addr_t'(res_idx >> 2);
        wr_req.data <= result_in.data;
    end

endmodule

/* tap_sequencer.sv */
`timescale 1ns/1ps

module tap_sequencer (
    input  logic                         clk,
    input  logic                         reset,
    input  cnn_stream_pkg::fetch_ctrl_t  fetch_ctrl,
    input  cnn_geom_pkg::pixel_t [3:0]   image_quad,
    input  cnn_geom_pkg::pixel_t         param_data,
    output cnn_stream_pkg::stream_beat_t beat
);
    import cnn_geom_pkg::*;
    import cnn_stream_pkg::*;

    pixel_t blk_buf [4][4];     // Row, column
    logic cap_valid;
    logic [1:0] cap_quad;
    step_t tap_idx;
    logic [1:0] tap_row;
    logic [1:0] tap_col;
    lane_word_u lanes;

    // Quad read on step s arrives one cycle later
    always_ff @(posedge clk) begin
        if (reset)
            cap_valid <= 1'b0;
        else
            cap_valid <= fetch_ctrl.active && fetch_ctrl.step < 4'd4;
        cap_quad <= fetch_ctrl.step[1:0];
    end

    always_ff @(posedge clk) begin
        if (cap_valid) begin
            for (int b = 0; b < 4; b++) begin
                // Bank b sits at offset (b div 2, b mod 2) inside the quad
                blk_buf[{cap_quad[1], b[1]}][{cap_quad[0], b[0]}] <= image_quad[b];
            end
        end
    end

    always_comb begin
        tap_idx = fetch_ctrl.step - 4'd5;
        tap_row = 2'(tap_idx / 3);
        tap_col = 2'(tap_idx % 3);
    end

    always_comb begin
        lanes = '0;
        beat  = '0;
        if (fetch_ctrl.active) begin
            if (fetch_ctrl.step == 4'd4) begin
                lanes.ctrl.kind      = BEAT_HEADER;
                lanes.ctrl.mac_count = 16'(TAPS);
                beat.valid           = 1'b1;
                beat.param           = param_data;    // Bias
            end else if (fetch_ctrl.step >= 4'd5 && int'(fetch_ctrl.step) < 5 + TAPS) begin
                // 2x2 window of the 4x4 buffer
                for (int j = 0; j < 4; j++) begin
                    lanes.pix[j] = blk_buf[int'(tap_row) + j / 2][int'(tap_col) + j % 2];
                end
                beat.valid = 1'b1;
                beat.tap   = 1'b1;
                beat.param = param_data;    // Weight for this tap
            end else if (int'(fetch_ctrl.step) == BLOCK_STEPS - 1) begin
                lanes.ctrl.kind = BEAT_SSFR;
                lanes.ctrl.ssfr = SSFR_INSTR;
                beat.valid      = 1'b1;
            end
        end
        beat.lanes = lanes;
    end

endmodule

/* block_fetch.sv */
`timescale 1ns/1ps

module block_fetch (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    output cnn_stream_pkg::fetch_ctrl_t fetch_ctrl,
    output cnn_geom_pkg::image_addr_t   image_addr,
    output cnn_geom_pkg::param_addr_t   param_addr,
    output logic                        busy,
    output logic                        done
);
    import cnn_geom_pkg::*;

    logic running;
    step_t step;
    logic [1:0] blk;                                       // Z-order slot in the group
    logic [$clog2(BLOCKS_PER_FILTER / 4) - 1:0] group;     // Raster index of 2x2 groups
    logic [$clog2(NUM_FILTERS) - 1:0] filter;
    logic [2:0] blk_row;
    logic [2:0] blk_col;
    image_addr_t base;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            done    <= 1'b0;
            step    <= '0;
            blk     <= '0;
            group   <= '0;
            filter  <= '0;
        end else begin
            done <= 1'b0;
            if (!running) begin
                if (start) begin
                    running <= 1'b1;
                    step    <= '0;
                    blk     <= '0;
                    group   <= '0;
                    filter  <= '0;
                end
            end else if (int'(step) == BLOCK_STEPS - 1) begin
                step <= '0;
                blk  <= blk + 2'd1;
                if (blk == 2'd3) begin
                    group <= group + 1'b1;
                    if (int'(group) == BLOCKS_PER_FILTER / 4 - 1) begin
                        filter <= filter + 1'b1;    // Wraps back for the next run
                        if (int'(filter) == NUM_FILTERS - 1) begin
                            running <= 1'b0;
                            done    <= 1'b1;
                        end
                    end
                end
            end else begin
                step <= step + 4'd1;
            end
        end
    end

    // Upper left quad of the current block
    always_comb begin
        blk_row = 3'(2 * (int'(group) / (BLOCKS_PER_ROW / 2)) + int'(blk[1]));
        blk_col = 3'(2 * (int'(group) % (BLOCKS_PER_ROW / 2)) + int'(blk[0]));
        base    = image_addr_t'(int'(blk_row) * QUADS_PER_ROW + int'(blk_col));
    end

    always_comb begin
        case (step)
            4'd1:    image_addr = base + 5'd1;
            4'd2:    image_addr = base + image_addr_t'(QUADS_PER_ROW);
            4'd3:    image_addr = base + image_addr_t'(QUADS_PER_ROW + 1);
            default: image_addr = base;
        endcase
    end

    // Bias on step 3, weights 1..9 on steps 4..12
    always_comb begin
        if (step >= 4'd3 && int'(step) <= 3 + PARAMS_PER_FILTER - 1)
            param_addr = param_addr_t'(int'(filter) * PARAMS_PER_FILTER + int'(step) - 3);
        else
            param_addr = param_addr_t'(int'(filter) * PARAMS_PER_FILTER);
    end

    assign fetch_ctrl = '{active: running, step: step};
    assign busy       = running;

endmodule

/* cnn_stream_pkg.sv */
package cnn_stream_pkg;

    import cnn_geom_pkg::*;

    typedef enum logic [7:0] {
        BEAT_HEADER = 8'h01,
        BEAT_SSFR   = 8'h02
    } beat_kind_e;

    // Control view of a lane word, MAC count sits in lanes 0 and 1
    typedef struct packed {
        pixel_t      ssfr;        // Lane 3
        beat_kind_e  kind;        // Lane 2
        logic [15:0] mac_count;
    } beat_ctrl_t;

    // Same 32 bits seen as pixels on tap beats or as control otherwise
    typedef union packed {
        pixel_t [3:0] pix;
        beat_ctrl_t   ctrl;
    } lane_word_u;

    typedef struct packed {
        logic       valid;
        lane_word_u lanes;
        pixel_t     param;    // Bias or weight
        logic       tap;      // Set on the nine tap beats
    } stream_beat_t;

    typedef struct packed {
        logic  active;
        step_t step;
    } fetch_ctrl_t;

    typedef struct packed {
        logic   valid;
        pixel_t data;
    } result_t;

    typedef struct packed {
        logic        valid;
        logic [1:0]  bank;
        store_addr_t addr;
        pixel_t      data;
    } bank_req_t;

endpackage

/* cnn_geom_pkg.sv */
package cnn_geom_pkg;

    // Image is held as 2x2 pixel quads, one pixel per bank
    localparam int QUADS_PER_ROW = 5;                    // 10x10 image
    localparam int BLOCKS_PER_ROW = QUADS_PER_ROW - 1;   // 4x4 blocks overlap by one quad

    localparam int BLOCKS_PER_FILTER = 16;
    localparam int NUM_FILTERS = 2;

    // Filter shape
    localparam int TAPS = 9;                  // 3x3 kernel
    localparam int PARAMS_PER_FILTER = 10;    // Bias followed by nine weights

    // Cycles spent on one block
    localparam int BLOCK_STEPS = 15;

    // Maxpool plus ReLU instruction for the SSFR unit
    localparam logic [7:0] SSFR_INSTR = 8'b1100_0001;

    typedef logic [4:0] image_addr_t;
    typedef logic [4:0] param_addr_t;
    typedef logic [5:0] store_addr_t;
    typedef logic [3:0] step_t;
    typedef logic [7:0] pixel_t;

endpackage
